//--- hw/rv_pipe_pkg.sv
// ############################
// shared types and decode helpers for the RV32I stage control
// opcode values are the RV32I major opcodes in bits 6..0
// field helpers decode fixed RV32I positions and do not check
// whether the instruction really has that field
// ############################

package rv_pipe_pkg;

    // major opcodes that the control logic tells apart
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_system = 7'b1110011
    } rv_opcode_e;

    // addi x0, x0, 0 is the word a bubble carries down the pipe
    localparam logic [31:0] nop_instr = 32'h0000_0013;

    // one stage register, valid is low for a bubble
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
    } stage_t;

    // wishbone classic master outputs
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    // wishbone classic slave response
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    function automatic logic [4:0] rd_of(input logic [31:0] instr);
        return instr[11:7];
    endfunction

    function automatic logic [4:0] rs1_of(input logic [31:0] instr);
        return instr[19:15];
    endfunction

    function automatic logic [4:0] rs2_of(input logic [31:0] instr);
        return instr[24:20];
    endfunction

    // stores and branches are the only formats without a destination
    function automatic logic writes_reg(input logic [31:0] instr);
        return (instr[6:0] != op_store) && (instr[6:0] != op_branch);
    endfunction

    function automatic logic is_mem_op(input logic [31:0] instr);
        return (instr[6:0] == op_load) || (instr[6:0] == op_store);
    endfunction

endpackage

//--- hw/hazard_unit.sv
// ############################
// read-after-write interlock without forwarding
// the consumer waits in ID until its producer has left WB
// rs2 is compared for every format, so some false hazards
// cost bubbles
// the back end only freezes on a global stall
// ############################

`timescale 1ns/10ps

module hazard_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_pipe_pkg::stage_t id,
    input  rv_pipe_pkg::stage_t ex,
    input  rv_pipe_pkg::stage_t mem,
    input  rv_pipe_pkg::stage_t wb,
    input  logic                bus_busy,
    output logic                stall_front,
    output logic                stall_ex,
    output logic                stall_mem,
    output logic                stall_wb
);
    import rv_pipe_pkg::*;

    // low in reset and in the first cycle after it
    logic       run;
    logic       stall_all;

    // extra cycles the front end still holds after a detected hazard
    logic [1:0] hold_cnt;

    // bits 2, 3 and 4 mark bubbles in EX, MEM and WB
    // bits 0 and 1 are bubbles still waiting to enter EX
    logic [4:0] bubble_sr;

    logic       dh_ex;
    logic       dh_mem;
    logic       dh_wb;
    logic       dh;

    // true when the consumer reads the destination of an older stage
    function automatic logic depends(input stage_t older, input logic ignore,
                                     input logic [31:0] consumer);
        logic [4:0] rd;
        rd = rd_of(older.instr);
        return !ignore && older.valid && writes_reg(older.instr) && (rd != 5'd0) &&
               ((rd == rs1_of(consumer)) || (rd == rs2_of(consumer)));
    endfunction

    assign stall_all = !run || bus_busy;

    // a stalled stage or one marked as a bubble never counts as a producer
    assign dh_ex  = id.valid && depends(ex, stall_all || bubble_sr[2], id.instr);
    assign dh_mem = id.valid && depends(mem, stall_all || bubble_sr[3], id.instr);
    assign dh_wb  = id.valid && depends(wb, stall_all || bubble_sr[4], id.instr);

    // while the counter runs the hazard is already being served
    assign dh = (dh_ex || dh_mem || dh_wb) && (hold_cnt == 2'd0);

    assign stall_front = stall_all || (hold_cnt != 2'd0) || dh;
    assign stall_ex    = stall_all;
    assign stall_mem   = stall_all;
    assign stall_wb    = stall_all;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run       <= 1'b0;
            hold_cnt  <= 2'd0;
            // the empty back end starts out as three bubbles
            bubble_sr <= 5'b11100;
        end else begin
            run <= 1'b1;
            if (dh) begin
                // the nearest producer decides how long ID must wait
                if (dh_ex) begin
                    hold_cnt  <= 2'd2;
                    bubble_sr <= {bubble_sr[3:0], 1'b0} | 5'b00111;
                end else if (dh_mem) begin
                    hold_cnt  <= 2'd1;
                    bubble_sr <= {bubble_sr[3:0], 1'b0} | 5'b00110;
                end else begin
                    hold_cnt  <= 2'd0;
                    bubble_sr <= {bubble_sr[3:0], 1'b0} | 5'b00100;
                end
            end else if (!stall_all) begin
                if (hold_cnt != 2'd0) begin
                    hold_cnt <= hold_cnt - 2'd1;
                end
                bubble_sr <= {bubble_sr[3:0], 1'b0};
            end
        end
    end

endmodule

//--- hw/stage_regs.sv
// ############################
// IF to WB instruction register chain
// a stage holds while its stall input is high
// bubbles carry valid low and the nop word
// ############################

`timescale 1ns/10ps

module stage_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_valid,
    input  logic [31:0]         fetch_instr,
    input  logic                stall_front,
    input  logic                stall_ex,
    input  logic                stall_mem,
    input  logic                stall_wb,
    output rv_pipe_pkg::stage_t id,
    output rv_pipe_pkg::stage_t ex,
    output rv_pipe_pkg::stage_t mem,
    output rv_pipe_pkg::stage_t wb,
    output logic                retire_valid,
    output logic [31:0]         retire_instr
);
    import rv_pipe_pkg::*;

    localparam stage_t bubble = '{valid: 1'b0, instr: nop_instr};

    stage_t if_stage;
    stage_t pd_stage;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_stage <= bubble;
            pd_stage <= bubble;
            id       <= bubble;
            ex       <= bubble;
            mem      <= bubble;
            wb       <= bubble;
        end else begin
            // IF, PD and ID always move together
            if (!stall_front) begin
                // an accepting edge with nothing offered loads a bubble
                if (fetch_valid) begin
                    if_stage <= '{valid: 1'b1, instr: fetch_instr};
                end else begin
                    if_stage <= bubble;
                end
                pd_stage <= if_stage;
                id       <= pd_stage;
            end
            // a held front end leaves ID in place, so EX gets a bubble
            if (!stall_ex) begin
                ex <= stall_front ? bubble : id;
            end
            if (!stall_mem) begin
                mem <= ex;
            end
            if (!stall_wb) begin
                wb <= mem;
            end
        end
    end

    // WB advances in the same cycle, so each instruction shows once
    assign retire_valid = wb.valid && !stall_wb;
    assign retire_instr = wb.instr;

endmodule

//--- hw/mem_bus_port.sv
// ############################
// wishbone classic master for the load or store in MEM
// one access per instruction, no pipelined or burst cycles
// the address is the zero-extended bits 31..20 of the word
// address bits at or above wb_addr_width are driven zero
// ############################

`timescale 1ns/10ps

module mem_bus_port #(
    parameter int wb_addr_width = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_pipe_pkg::stage_t  mem,
    output rv_pipe_pkg::wb_req_t wb_req,
    input  rv_pipe_pkg::wb_rsp_t wb_rsp,
    output logic                 bus_busy,
    output logic [31:0]          load_data
);
    import rv_pipe_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_done
    } bus_state_e;

    localparam logic [31:0] adr_mask = 32'((64'd1 << wb_addr_width) - 64'd1);

    bus_state_e  state;
    logic        start;
    logic [31:0] rdata_q;

    // in idle every memory instruction in MEM is a new one
    assign start = (state == st_idle) && mem.valid && is_mem_op(mem.instr);

    // the setup cycle and the whole bus cycle freeze the pipe
    assign bus_busy = start || (state == st_request);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state      <= st_request;
                        wb_req.cyc <= 1'b1;
                        wb_req.stb <= 1'b1;
                        wb_req.we  <= (mem.instr[6:0] == op_store);
                        wb_req.adr <= {20'd0, mem.instr[31:20]} & adr_mask;
                        wb_req.dat <= mem.instr;
                        wb_req.sel <= 4'hf;
                    end
                end
                st_request: begin
                    // the request stays put until the slave acknowledges
                    if (wb_rsp.ack) begin
                        state      <= st_done;
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        rdata_q    <= wb_rsp.dat;
                    end
                end
                // MEM always advances out of done since busy is low there
                default: state <= st_idle;
            endcase
        end
    end

    // follows the instruction from MEM into WB
    always_ff @(posedge clk) begin
        if (!bus_busy) begin
            if (mem.valid && (mem.instr[6:0] == op_load)) begin
                load_data <= rdata_q;
            end else begin
                load_data <= 32'd0;
            end
        end
    end

endmodule

//--- hw/pipe_ctrl_top.sv
// ############################
// stage control for a six-stage in-order RV32I pipe
// fetch uses a ready/valid pair, data uses wishbone classic
// no forwarding, no branches and no interrupts
// ############################

`timescale 1ns/10ps

module pipe_ctrl_top #(
    parameter int wb_addr_width = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_valid,
    input  logic [31:0]          fetch_instr,
    output logic                 fetch_ready,
    output logic                 retire_valid,
    output logic [31:0]          retire_instr,
    output logic [31:0]          retire_rdata,
    output rv_pipe_pkg::wb_req_t wb_req,
    input  rv_pipe_pkg::wb_rsp_t wb_rsp
);
    import rv_pipe_pkg::*;

    stage_t id;
    stage_t ex;
    stage_t mem;
    stage_t wb;
    logic   bus_busy;
    logic   stall_front;
    logic   stall_ex;
    logic   stall_mem;
    logic   stall_wb;

    // IF takes a word only when the front end moves
    assign fetch_ready = !stall_front;

    hazard_unit u_hazard_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .id          (id),
        .ex          (ex),
        .mem         (mem),
        .wb          (wb),
        .bus_busy    (bus_busy),
        .stall_front (stall_front),
        .stall_ex    (stall_ex),
        .stall_mem   (stall_mem),
        .stall_wb    (stall_wb)
    );

    stage_regs u_stage_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .stall_front  (stall_front),
        .stall_ex     (stall_ex),
        .stall_mem    (stall_mem),
        .stall_wb     (stall_wb),
        .id           (id),
        .ex           (ex),
        .mem          (mem),
        .wb           (wb),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr)
    );

    // load data arrives already aligned with the WB stage
    mem_bus_port #(
        .wb_addr_width (wb_addr_width)
    ) u_mem_bus_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem       (mem),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .bus_busy  (bus_busy),
        .load_data (retire_rdata)
    );

endmodule

//--- testbench/pipe_ctrl_checker.sv
// ############################
// assertions on the wishbone master and the stall outputs
// bound into pipe_ctrl_top, where both blocks meet
// the first cycle after reset is a global stall and is skipped
// ############################

`timescale 1ns/10ps

module pipe_ctrl_checker (
    input logic                 clk,
    input logic                 rst_n,
    input rv_pipe_pkg::wb_req_t wb_req,
    input rv_pipe_pkg::wb_rsp_t wb_rsp,
    input rv_pipe_pkg::stage_t  id,
    input logic                 bus_busy,
    input logic                 stall_front,
    input logic                 stall_ex,
    input logic                 stall_mem,
    input logic                 stall_wb
);
    import rv_pipe_pkg::*;

    // a strobe is only legal inside an open cycle
    assert property (@(posedge clk) disable iff (!rst_n) wb_req.stb |-> wb_req.cyc)
        else $error("wishbone stb seen without cyc");

    // an unacknowledged request keeps every field until the slave answers
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req))
        else $error("wishbone request changed before ack");

    // without a bus cycle only a consumer waiting in ID may hold any stage
    assert property (@(posedge clk) disable iff (!rst_n)
        !bus_busy && $past(rst_n) && !id.valid |->
            !stall_front && !stall_ex && !stall_mem && !stall_wb)
        else $error("stall active with no bus cycle and no instruction in ID");

    // EX never moves ahead of a held front end
    assert property (@(posedge clk) disable iff (!rst_n) stall_ex |-> stall_front)
        else $error("stall_ex active while stall_front is low");

endmodule

//--- testbench/pipe_ctrl_tb.sv
// ############################
// directed tests for pipe_ctrl_top with the default address width
// the wishbone slave answers every access after 0 to 4 wait states
// outputs are sampled at the falling edge, inputs change 10 ns after
// the rising edge
// the first error stops the run
// ############################

`timescale 1ns/10ps

module pipe_ctrl_tb;
    import rv_pipe_pkg::*;

    localparam int clk_period  = 100;
    localparam int drive_delay = 10;
    // instructions sent by the five tests, in order
    localparam int total_instr = 10 + 20 + 8 + 12 + 2;

    // one expected retirement, gap counts retire_valid low cycles before it
    typedef struct packed {
        logic [31:0] instr;
        logic [3:0]  gap;
        logic        chk_gap;
        logic        chk_lat;
        logic [31:0] accepted;
    } retire_exp_t;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    logic [31:0] fetch_instr;
    logic        fetch_ready;
    logic        retire_valid;
    logic [31:0] retire_instr;
    logic [31:0] retire_rdata;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    retire_exp_t exp_q[$];
    wb_req_t     access_q[$];
    logic [31:0] rdata_q[$];
    retire_exp_t mon_exp;
    logic [31:0] cycle;
    int          idle_cnt;
    int          wait_left;

    pipe_ctrl_top u_pipe_ctrl_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_instr  (fetch_instr),
        .fetch_ready  (fetch_ready),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .retire_rdata (retire_rdata),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp)
    );

    bind pipe_ctrl_top pipe_ctrl_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .id          (id),
        .bus_busy    (bus_busy),
        .stall_front (stall_front),
        .stall_ex    (stall_ex),
        .stall_mem   (stall_mem),
        .stall_wb    (stall_wb)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 32'd1;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_instr(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_wb_req(input wb_req_t got, input wb_req_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED wb_req: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    // R-type add, the only ALU format used so rs1 and rs2 are explicit
    function automatic logic [31:0] alu_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'd0, rd, op_reg};
    endfunction

    function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd0, 3'b010, rd, op_load};
    endfunction

    // rs1 and rs2 stay x0, imm[4:0] sits where a destination would be
    function automatic logic [31:0] store_word(input logic [11:0] imm);
        return {imm[11:5], 5'd0, 5'd0, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] branch_word(input logic [4:0] imm_lo);
        return {7'd0, 5'd0, 5'd0, 3'd0, imm_lo, op_branch};
    endfunction

    // access that the wishbone rules give for a memory instruction
    function automatic wb_req_t expected_req(input logic [31:0] instr);
        wb_req_t r;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = (instr[6:0] == op_store);
        r.adr = {20'd0, instr[31:20]};
        r.dat = instr;
        r.sel = 4'hf;
        return r;
    endfunction

    // offers one word and returns 10 ns after the edge that took it
    task automatic send(input logic [31:0] instr, input logic [3:0] gap,
                        input logic chk_gap, input logic chk_lat);
        retire_exp_t e;
        fetch_valid = 1'b1;
        fetch_instr = instr;
        do begin
            @(negedge clk);
        end while (!fetch_ready);
        @(posedge clk);
        #drive_delay;
        fetch_valid = 1'b0;
        e.instr    = instr;
        e.gap      = gap;
        e.chk_gap  = chk_gap;
        e.chk_lat  = chk_lat;
        e.accepted = cycle;
        exp_q.push_back(e);
    endtask

    task automatic idle_cycles(input int n);
        fetch_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #drive_delay;
        end
    endtask

    // waits until everything sent has retired and every access was claimed
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        check_count("unclaimed bus accesses", access_q.size(), 0);
        check_count("unclaimed read data", rdata_q.size(), 0);
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (8) begin
            @(posedge clk);
            #drive_delay;
        end
        rst_n = 1'b1;
    endtask

    // the retirement monitor, also checks every bus access
    always @(negedge clk) begin
        if (wb_req.cyc && fetch_ready) begin
            report_failure("fetch_ready was high while a bus cycle was open");
        end
        if (retire_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("an instruction retired that was never sent");
            end
            mon_exp = exp_q.pop_front();
            check_instr("retire_instr", retire_instr, mon_exp.instr);
            if (mon_exp.instr[6:0] == op_load) begin
                if (rdata_q.size() == 0) begin
                    report_failure("a load retired without any read data returned");
                end
                check_instr("retire_rdata", retire_rdata, rdata_q.pop_front());
            end else begin
                check_instr("retire_rdata", retire_rdata, 32'd0);
            end
            if (is_mem_op(mon_exp.instr)) begin
                if (access_q.size() == 0) begin
                    report_failure("a memory instruction retired without a bus access");
                end
                check_wb_req(access_q.pop_front(), expected_req(mon_exp.instr));
            end
            if (mon_exp.chk_gap) begin
                check_count("bubble cycles", idle_cnt, int'(mon_exp.gap));
            end
            if (mon_exp.chk_lat) begin
                check_count("retire latency", cycle - mon_exp.accepted, 5);
            end
            idle_cnt = 0;
        end else begin
            idle_cnt = idle_cnt + 1;
        end
    end

    // wishbone slave, records each access and acks after random wait states
    always @(posedge clk) begin
        #drive_delay;
        if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;
        end else if (rst_n && wb_req.cyc && wb_req.stb) begin
            if (wait_left < 0) begin
                access_q.push_back(wb_req);
                wait_left = $urandom_range(4, 0);
            end
            if (wait_left == 0) begin
                wb_rsp.ack = 1'b1;
                wb_rsp.dat = $urandom;
                if (!wb_req.we) begin
                    rdata_q.push_back(wb_rsp.dat);
                end
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // ten independent adds, back to back and five edges deep
    task automatic straight_line_flow();
        for (int i = 0; i < 10; i++) begin
            send(alu_word(5'(i + 1), 5'd0, 5'd0), 4'd0, (i != 0), 1'b1);
        end
        drain();
    endtask

    task automatic distance_interlock();
        for (int d = 1; d <= 4; d++) begin
            send(alu_word(5'(d + 1), 5'd0, 5'd0), 4'd0, (d != 1), 1'b0);
            for (int k = 1; k < d; k++) begin
                send(alu_word(5'd12, 5'd0, 5'd0), 4'd0, 1'b1, 1'b0);
            end
            // the consumer leaves ID only once its producer is gone from WB
            send(alu_word(5'(d + 20), 5'(d + 1), 5'd0), 4'(d < 4 ? 4 - d : 0), 1'b1, 1'b0);
        end
        // x0 destination that the store two places behind reads
        send(alu_word(5'd0, 5'd0, 5'd0), 4'd0, 1'b1, 1'b0);
        // this one reads only x9 and waits in WB behind the store's bus cycle
        send(alu_word(5'd26, 5'd9, 5'd9), 4'd0, 1'b0, 1'b0);
        send(store_word(12'h0a8), 4'd0, 1'b1, 1'b0);
        send(alu_word(5'd28, 5'd8, 5'd0), 4'd0, 1'b1, 1'b0);
        send(branch_word(5'd7), 4'd0, 1'b1, 1'b0);
        send(alu_word(5'd27, 5'd7, 5'd0), 4'd0, 1'b1, 1'b0);
        drain();
    endtask

    task automatic loads_and_stores();
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                send(load_word(5'(13 + i), 12'($urandom_range(4095, 0))), 4'd0, 1'b0, 1'b0);
            end else begin
                send(store_word(12'($urandom_range(4095, 0))), 4'd0, 1'b0, 1'b0);
            end
        end
        drain();
    endtask

    // memory and ALU words mixed with fetch gaps, wait states stall everything
    task automatic wait_state_pressure();
        for (int i = 0; i < 12; i++) begin
            case (i % 3)
                0: send(load_word(5'(14 + i), 12'($urandom_range(4095, 0))), 4'd0, 1'b0, 1'b0);
                1: send(alu_word(5'd30, 5'd0, 5'd0), 4'd0, 1'b0, 1'b0);
                default: send(store_word(12'($urandom_range(4095, 0))), 4'd0, 1'b0, 1'b0);
            endcase
            idle_cycles($urandom_range(2, 0));
        end
        drain();
    endtask

    task automatic reset_then_hazard();
        rst_n = 1'b0;
        repeat (8) begin
            @(posedge clk);
            #drive_delay;
            check_bit("fetch_ready", fetch_ready, 1'b0);
            check_bit("retire_valid", retire_valid, 1'b0);
            check_bit("wb_req.cyc", wb_req.cyc, 1'b0);
        end
        rst_n = 1'b1;
        // distance 1 right after reset still costs three bubbles
        send(alu_word(5'd6, 5'd0, 5'd0), 4'd0, 1'b0, 1'b0);
        send(alu_word(5'd7, 5'd6, 5'd0), 4'd3, 1'b1, 1'b0);
        drain();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_instr = nop_instr;
        wb_rsp      = '0;
        cycle       = 32'd0;
        idle_cnt    = 0;
        wait_left   = -1;
        void'($urandom(21650));
        apply_reset();
        straight_line_flow();
        distance_interlock();
        loads_and_stores();
        wait_state_pressure();
        reset_then_hazard();
        $display("=== PASS ===");
        $finish;
    end

    // each instruction gets twenty cycles before the run counts as hung
    initial begin
        #(total_instr * 20 * clk_period);
        report_failure("the run hung, the tests did not finish in time");
    end

endmodule

//--- pipe_ctrl_top.f
hw/rv_pipe_pkg.sv
hw/hazard_unit.sv
hw/stage_regs.sv
hw/mem_bus_port.sv
hw/pipe_ctrl_top.sv
testbench/pipe_ctrl_checker.sv
testbench/pipe_ctrl_tb.sv

//--- Bender.yml
package:
  name: pipe_ctrl

sources:
  - files:
      - hw/rv_pipe_pkg.sv
      - hw/hazard_unit.sv
      - hw/stage_regs.sv
      - hw/mem_bus_port.sv
      - hw/pipe_ctrl_top.sv
  - target: test
    files:
      - testbench/pipe_ctrl_checker.sv
      - testbench/pipe_ctrl_tb.sv
